//--- vlog.f
sparcPkg.sv
controlDecoder.sv
regArray.sv
operandPort.sv
branchCondition.sv
idExRegister.sv
decodeStage.sv
tbDecodeStage.sv

//--- Makefile
# Verilator build and run of the decode stage testbench
TOP = tbDecodeStage

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and fail if the log reports failure"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if grep -q "TEST FAILED" sim.log; then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir sim.log

//--- tbDecodeStage.sv
`timescale 1ns/1ps

module tbDecodeStage import sparcPkg::*;
();

    localparam int TimeoutCycles = 2000;    // Whole run needs roughly 400 cycles

    // Arithmetic op3 codes and the ALU code each one must produce
    localparam logic [5:0] ArithOp3 [13] = '{6'h00, 6'h08, 6'h04, 6'h0C, 6'h01, 6'h02,
                                             6'h03, 6'h07, 6'h05, 6'h06, 6'h25, 6'h26, 6'h27};
    localparam aluOp_t ArithAlu [13] = '{ALU_ADD, ALU_ADDX, ALU_SUB, ALU_SUBX, ALU_AND, ALU_OR,
                                         ALU_XOR, ALU_XNOR, ALU_ANDN, ALU_ORN, ALU_SLL,
                                         ALU_SRL, ALU_SRA};

    localparam logic [5:0] MemOp3 [8] = '{OP3_LD, OP3_LDUB, OP3_LDUH, OP3_LDSB, OP3_LDSH,
                                          OP3_ST, OP3_STB, OP3_STH};
    localparam logic MemLoad [8]   = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
    localparam logic MemSigned [8] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
    localparam memSize_t MemSize [8] = '{SIZE_WORD, SIZE_BYTE, SIZE_HALF, SIZE_BYTE, SIZE_HALF,
                                         SIZE_WORD, SIZE_BYTE, SIZE_HALF};

    localparam logic [XLEN-1:0] ExValue  = 32'hE0E0_0001;
    localparam logic [XLEN-1:0] MemValue = 32'hA0A0_0002;
    localparam logic [XLEN-1:0] WbValue  = 32'hB0B0_0003;

    logic            Clk;
    logic            rstN;
    logic [XLEN-1:0] instr;
    fwdSrc_t         exFwd;
    fwdSrc_t         memFwd;
    fwdSrc_t         wbFwd;
    logic            exIsLoad;
    cc_t             exFlags;
    logic            exModifyCc;
    idEx_t           idEx;
    logic            stall;
    logic            branchTaken;
    logic            annul;

    int              errCount   = 0;
    int              cycleCount = 0;
    logic [XLEN-1:0] regModel [NUM_REGS] = '{default: '0};   // Expected register contents

    decodeStage #(.NumRegs(NUM_REGS), .NumReadPorts(NUM_READ_PORTS)) i_decodeStage (
        .Clk         (Clk),
        .rstN        (rstN),
        .instr       (instr),
        .exFwd       (exFwd),
        .memFwd      (memFwd),
        .wbFwd       (wbFwd),
        .exIsLoad    (exIsLoad),
        .exFlags     (exFlags),
        .exModifyCc  (exModifyCc),
        .idEx        (idEx),
        .stall       (stall),
        .branchTaken (branchTaken),
        .annul       (annul)
    );

    initial
    begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    always @(posedge Clk)
        cycleCount <= cycleCount + 1;

    initial
    begin
        wait (cycleCount >= TimeoutCycles);
        $display("Timeout, run did not finish within %0d cycles", TimeoutCycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic checkVal(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            errCount++;
            $display("ERR %s got %0h expected %0h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] arithInstr(input logic [5:0] op3, input logic [4:0] rd,
                                               input logic [4:0] rs1, input logic [4:0] rs2);
        return {OP_ARITH, rd, op3, rs1, 1'b0, 8'h00, rs2};
    endfunction

    function automatic logic [31:0] branchInstr(input logic a, input logic [3:0] cond);
        return {OP_BRANCH, a, cond, 3'b010, 22'h00_0040};   // Bicc
    endfunction

    // SPARC icc conditions, upper half negates the lower half
    function automatic logic branchModel(input logic [3:0] cond, input cc_t f);
        logic base;
        case (cond[2:0])
            3'd0:    base = 1'b0;
            3'd1:    base = f.z;
            3'd2:    base = f.z | (f.n ^ f.v);
            3'd3:    base = f.n ^ f.v;
            3'd4:    base = f.c | f.z;
            3'd5:    base = f.c;
            3'd6:    base = f.n;
            default: base = f.v;
        endcase
        return base ^ cond[3];
    endfunction

    task automatic drive(input logic [31:0] value);
        @(negedge Clk);
        instr = value;
        #1;
    endtask

    task automatic tick();
        @(posedge Clk);
        #1;
    endtask

    task automatic checkDecode(input logic [31:0] value, input exCtrl_t exp,
                               input logic [4:0] expRd);
        drive(value);
        tick();
        checkVal("idEx.ctrl", 64'(idEx.ctrl), 64'(exp));
        checkVal("idEx.rd", 64'(idEx.rd), 64'(expRd));
    endtask

    task automatic testReset();
        assert (idEx === '0)
        else
        begin
            errCount++;
            $display("ERR idEx got %h expected 0", idEx);
        end
        drive(branchInstr(1'b0, COND_BE));
        checkVal("branchTaken", 64'(branchTaken), 64'd0);    // PSR still zero
    endtask

    task automatic testDecode();
        exCtrl_t    exp;
        logic [5:0] op3;
        for (int k = 0; k < 13; k++)
        begin
            for (int cc = 0; cc < 2; cc++)
            begin
                op3          = ArithOp3[k];
                op3[4]       = cc[0];     // The cc variant of the same op
                exp          = '0;
                exp.rfEnable = 1'b1;
                exp.aluOp    = ArithAlu[k];
                exp.modifyCc = cc[0];
                checkDecode(arithInstr(op3, 5'd4, 5'd1, 5'd2), exp, 5'd4);
                checkVal("idEx.isImm", 64'(idEx.isImm), 64'd0);
            end
        end
        for (int k = 0; k < 8; k++)
        begin
            exp           = '0;
            exp.memEnable = 1'b1;
            exp.load      = MemLoad[k];
            exp.store     = !MemLoad[k];
            exp.rfEnable  = MemLoad[k];
            exp.signExt   = MemSigned[k];
            exp.size      = MemSize[k];
            checkDecode({OP_MEM, 5'd6, MemOp3[k], 5'd1, 1'b1, 13'h0010}, exp, 5'd6);
            checkVal("idEx.isImm", 64'(idEx.isImm), 64'd1);
        end
        exp          = '0;
        exp.aluOp    = ALU_PASSB;
        exp.rfEnable = 1'b1;
        checkDecode({OP_BRANCH, 5'd11, OP2_SETHI, 22'h2A_5A5A}, exp, 5'd11);
        checkVal("idEx.imm22", 64'(idEx.imm22), 64'h2A_5A5A);
        exp          = '0;
        exp.call     = 1'b1;
        exp.rfEnable = 1'b1;
        checkDecode({OP_CALL, 30'h0000_1234}, exp, LINK_REG);
        exp          = '0;
        exp.jmpl     = 1'b1;        // Its op3 has bit 23 set, still no cc update
        exp.rfEnable = 1'b1;
        checkDecode(arithInstr(OP3_JMPL, 5'd13, 5'd1, 5'd2), exp, 5'd13);
    endtask

    task automatic testRegFile();
        logic [XLEN-1:0] value;
        @(negedge Clk);
        instr = '0;
        wbFwd = '{rfEnable: 1'b1, rd: 5'd0, value: 32'hDEAD_BEEF};   // Must not land in r0
        for (int r = 1; r < NUM_REGS; r++)
        begin
            @(negedge Clk);
            value       = $urandom;
            wbFwd       = '{rfEnable: 1'b1, rd: 5'(r), value: value};
            regModel[r] = value;
        end
        @(negedge Clk);
        wbFwd = '0;
        for (int r = 0; r < NUM_REGS; r++)
        begin
            drive(arithInstr(6'h02, 5'(r), 5'(r), 5'(31 - r)));
            tick();
            checkVal("idEx.opA", 64'(idEx.opA), 64'(regModel[r]));
            checkVal("idEx.opB", 64'(idEx.opB), 64'(regModel[31 - r]));
            checkVal("idEx.storeData", 64'(idEx.storeData), 64'(regModel[r]));
        end
    endtask

    // enable bits are EX, MEM, WB from high to low
    task automatic checkForward(input logic [2:0] enable, input logic [4:0] addr,
                                input logic [XLEN-1:0] exp);
        @(negedge Clk);
        exFwd  = '{rfEnable: enable[2], rd: addr, value: ExValue};
        memFwd = '{rfEnable: enable[1], rd: addr, value: MemValue};
        wbFwd  = '{rfEnable: enable[0], rd: addr, value: WbValue};
        instr  = arithInstr(6'h02, addr, addr, 5'd0);
        tick();
        checkVal("idEx.opA", 64'(idEx.opA), 64'(exp));
        checkVal("idEx.storeData", 64'(idEx.storeData), 64'(exp));
        if (enable[0] && addr != '0)
            regModel[addr] = WbValue;
    endtask

    task automatic testForwarding();
        checkForward(3'b111, 5'd5, ExValue);
        checkForward(3'b101, 5'd5, ExValue);
        checkForward(3'b011, 5'd5, MemValue);
        checkForward(3'b001, 5'd6, WbValue);       // r6 still holds its random value
        checkForward(3'b000, 5'd6, regModel[6]);   // WB write above is now in the file
        checkForward(3'b111, 5'd0, '0);
        @(negedge Clk);
        exFwd  = '0;
        memFwd = '0;
        wbFwd  = '0;
    endtask

    task automatic testLoadUse();
        exCtrl_t exp;
        exp          = '0;
        exp.rfEnable = 1'b1;       // Plain add
        @(negedge Clk);
        exIsLoad = 1'b1;
        exFwd    = '{rfEnable: 1'b1, rd: 5'd7, value: '0};
        instr    = arithInstr(6'h00, 5'd9, 5'd7, 5'd0);
        #1;
        checkVal("stall", 64'(stall), 64'd1);
        tick();
        checkVal("idEx.ctrl", 64'(idEx.ctrl), 64'd0);
        @(negedge Clk);
        exIsLoad = 1'b0;           // Same instr held, load has moved on
        exFwd    = '0;
        #1;
        checkVal("stall", 64'(stall), 64'd0);
        tick();
        checkVal("idEx.ctrl", 64'(idEx.ctrl), 64'(exp));
        @(negedge Clk);
        exIsLoad = 1'b1;
        exFwd    = '{rfEnable: 1'b1, rd: 5'd8, value: '0};
        #1;
        checkVal("stall", 64'(stall), 64'd0);
        tick();
        checkVal("idEx.ctrl", 64'(idEx.ctrl), 64'(exp));
        @(negedge Clk);
        exFwd.rd = 5'd4;
        instr    = {OP_ARITH, 5'd9, 6'h00, 5'd7, 1'b1, 13'h0004};   // Low bits are an immediate
        #1;
        checkVal("stall", 64'(stall), 64'd0);
        @(negedge Clk);
        exIsLoad = 1'b0;
        exFwd    = '0;
    endtask

    // With fromEx the EX flags alternate between ~f and f, so the PSR always lags behind
    task automatic checkAllConds(input cc_t f, input logic fromEx);
        logic a;
        cc_t  flags;
        for (int c = 0; c < 16; c++)
        begin
            a     = 1'($urandom);
            flags = (fromEx && !c[0]) ? ~f : f;
            @(negedge Clk);
            instr = branchInstr(a, 4'(c));
            if (fromEx)
                exFlags = flags;
            #1;
            checkVal("branchTaken", 64'(branchTaken), 64'(branchModel(4'(c), flags)));
            checkVal("annul", 64'(annul), 64'(a));
        end
    endtask

    task automatic testBranch();
        cc_t f;
        for (int i = 0; i < 8; i++)
        begin
            f = cc_t'(4'($urandom));
            @(negedge Clk);
            exModifyCc = 1'b1;
            exFlags    = f;
            checkAllConds(f, 1'b1);    // Flags taken straight from EX
            @(negedge Clk);
            exModifyCc = 1'b0;
            exFlags    = ~f;        // Ignored now, PSR holds f
            checkAllConds(f, 1'b0);
        end
    endtask

    initial
    begin
        void'($urandom(44186));
        rstN       = 1'b0;
        instr      = '0;
        exFwd      = '0;
        memFwd     = '0;
        wbFwd      = '0;
        exIsLoad   = 1'b0;
        exFlags    = '0;
        exModifyCc = 1'b0;
        repeat (5) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;
        tick();

        testReset();
        testDecode();
        testRegFile();
        testForwarding();
        testLoadUse();
        testBranch();

        $display("Errors counted: %0d", errCount);
        if (errCount == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- decodeStage.sv
`timescale 1ns/1ps

module decodeStage import sparcPkg::*;
#(
    parameter int NumRegs      = NUM_REGS,
    parameter int NumReadPorts = NUM_READ_PORTS
)
(
    input  logic            Clk,
    input  logic            rstN,
    input  logic [XLEN-1:0] instr,
    input  fwdSrc_t         exFwd,
    input  fwdSrc_t         memFwd,
    input  fwdSrc_t         wbFwd,
    input  logic            exIsLoad,
    input  cc_t             exFlags,
    input  logic            exModifyCc,
    output idEx_t           idEx,
    output logic            stall,
    output logic            branchTaken,
    output logic            annul
);

    ctrl_t                   ctrl;
    logic [REG_ADDR_W-1:0]   rd;
    logic [NumRegs*XLEN-1:0] regs;
    logic [REG_ADDR_W-1:0]   readAddr [NumReadPorts];
    logic [XLEN-1:0]         operand  [NumReadPorts];

    assign readAddr[0] = instr[18:14];    // rs1
    assign readAddr[1] = instr[4:0];      // rs2
    assign readAddr[2] = instr[29:25];    // Store data sits in the rd field

    controlDecoder i_controlDecoder (
        .instr (instr),
        .ctrl  (ctrl),
        .rd    (rd)
    );

    regArray #(.NumRegs(NumRegs)) i_regArray (
        .Clk   (Clk),
        .rstN  (rstN),
        .wbFwd (wbFwd),
        .regs  (regs)
    );

    for (genvar k = 0; k < NumReadPorts; k++)
    begin : gPort
        operandPort #(.NumRegs(NumRegs)) i_operandPort (
            .addr    (readAddr[k]),
            .regs    (regs),
            .exFwd   (exFwd),
            .memFwd  (memFwd),
            .wbFwd   (wbFwd),
            .operand (operand[k])
        );
    end

    branchCondition i_branchCondition (
        .Clk         (Clk),
        .rstN        (rstN),
        .instr       (instr),
        .ctrl        (ctrl),
        .exFlags     (exFlags),
        .exModifyCc  (exModifyCc),
        .branchTaken (branchTaken),
        .annul       (annul)
    );

    idExRegister i_idExRegister (
        .Clk       (Clk),
        .rstN      (rstN),
        .instr     (instr),
        .ctrl      (ctrl),
        .rd        (rd),
        .opA       (operand[0]),
        .opB       (operand[1]),
        .storeData (operand[2]),
        .exFwd     (exFwd),
        .exIsLoad  (exIsLoad),
        .stall     (stall),
        .idEx      (idEx)
    );

endmodule

//--- idExRegister.sv
`timescale 1ns/1ps

module idExRegister import sparcPkg::*;
(
    input  logic                  Clk,
    input  logic                  rstN,
    input  logic [XLEN-1:0]       instr,
    input  ctrl_t                 ctrl,
    input  logic [REG_ADDR_W-1:0] rd,
    input  logic [XLEN-1:0]       opA,
    input  logic [XLEN-1:0]       opB,
    input  logic [XLEN-1:0]       storeData,
    input  fwdSrc_t               exFwd,
    input  logic                  exIsLoad,
    output logic                  stall,
    output idEx_t                 idEx
);

    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  isImm;
    idEx_t                 nextIdEx;

    assign rs1   = instr[18:14];
    assign rs2   = instr[4:0];
    assign isImm = instr[13];

    // Load result is not ready until MEM, so hold ID one cycle
    assign stall = exIsLoad && (exFwd.rd != '0) &&
                   ((exFwd.rd == rs1) || (!isImm && exFwd.rd == rs2));

    always_comb
    begin
        nextIdEx = '0;
        if (!stall)
            nextIdEx.ctrl = '{jmpl: ctrl.jmpl, store: ctrl.store, aluOp: ctrl.aluOp,
                              signExt: ctrl.signExt, load: ctrl.load,
                              rfEnable: ctrl.rfEnable, size: ctrl.size,
                              modifyCc: ctrl.modifyCc, call: ctrl.call,
                              memEnable: ctrl.memEnable};
        nextIdEx.opA       = opA;
        nextIdEx.opB       = opB;
        nextIdEx.storeData = storeData;
        nextIdEx.rd        = rd;
        nextIdEx.imm22     = instr[21:0];
        nextIdEx.isImm     = isImm;
    end

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            idEx <= '0;     // Starts as a nop
        else
            idEx <= nextIdEx;
    end

    // The bubble moves into EX behind the load, so a stall lasts one cycle
    singleCycleStall: assert property (
        @(posedge Clk) disable iff (!rstN)
        stall |=> !stall
    ) else $error("load-use stall lasted more than one cycle");

endmodule

//--- branchCondition.sv
`timescale 1ns/1ps

module branchCondition import sparcPkg::*;
(
    input  logic            Clk,
    input  logic            rstN,
    input  logic [XLEN-1:0] instr,
    input  ctrl_t           ctrl,
    input  cc_t             exFlags,
    input  logic            exModifyCc,
    output logic            branchTaken,
    output logic            annul
);

    cc_t        psr;         // Only the icc field is kept
    cc_t        cc;
    logic [3:0] cond;
    logic       condTrue;

    always_ff @(posedge Clk)
    begin
        if (!rstN)
            psr <= '0;
        else if (exModifyCc)
            psr <= exFlags;
    end

    // Flags still in EX are newer than the PSR
    assign cc   = exModifyCc ? exFlags : psr;
    assign cond = instr[28:25];

    always_comb
    begin
        case (cond)
            COND_BA:   condTrue = 1'b1;
            COND_BN:   condTrue = 1'b0;
            COND_BNE:  condTrue = !cc.z;
            COND_BE:   condTrue = cc.z;
            COND_BG:   condTrue = !(cc.z || (cc.n ^ cc.v));
            COND_BLE:  condTrue = cc.z || (cc.n ^ cc.v);
            COND_BGE:  condTrue = !(cc.n ^ cc.v);
            COND_BL:   condTrue = cc.n ^ cc.v;
            COND_BGU:  condTrue = !cc.c && !cc.z;     // Both clear
            COND_BLEU: condTrue = cc.c || cc.z;
            COND_BCC:  condTrue = !cc.c;
            COND_BCS:  condTrue = cc.c;
            COND_BPOS: condTrue = !cc.n;
            COND_BNEG: condTrue = cc.n;
            COND_BVC:  condTrue = !cc.v;
            COND_BVS:  condTrue = cc.v;
            default:   condTrue = 1'b0;
        endcase
    end

    assign branchTaken = ctrl.branch && condTrue;
    assign annul       = ctrl.annulBit;   // Decoder sets it only on branches

    // Annul only ever comes with a branch from the decoder
    annulOnBranch: assert property (
        @(posedge Clk) disable iff (!rstN)
        annul |-> ctrl.branch
    ) else $error("annul raised on a non-branch instruction");

endmodule

//--- operandPort.sv
`timescale 1ns/1ps

module operandPort import sparcPkg::*;
#(
    parameter int NumRegs = NUM_REGS
)
(
    input  logic [REG_ADDR_W-1:0]   addr,
    input  logic [NumRegs*XLEN-1:0] regs,
    input  fwdSrc_t                 exFwd,
    input  fwdSrc_t                 memFwd,
    input  fwdSrc_t                 wbFwd,
    output logic [XLEN-1:0]         operand
);

    logic [XLEN-1:0] regValue;
    logic            hitEx;
    logic            hitMem;
    logic            hitWb;

    assign regValue = regs[addr*XLEN +: XLEN];

    // r0 is never forwarded
    assign hitEx  = (addr != '0) && exFwd.rfEnable  && (exFwd.rd == addr);
    assign hitMem = (addr != '0) && memFwd.rfEnable && (memFwd.rd == addr);
    assign hitWb  = (addr != '0) && wbFwd.rfEnable  && (wbFwd.rd == addr);

    always_comb
    begin
        if (hitEx)
            operand = exFwd.value;        // Youngest result first
        else if (hitMem)
            operand = memFwd.value;
        else if (hitWb)
            operand = wbFwd.value;
        else
            operand = regValue;

        // Zero comes from regArray slot 0, nothing here forces it
        if (addr == '0)
            zeroAddrRead: assert (operand == '0)
                else $error("read of r0 returned %h", operand);
    end

endmodule

//--- regArray.sv
`timescale 1ns/1ps

module regArray import sparcPkg::*;
#(
    parameter int NumRegs = NUM_REGS
)
(
    input  logic                    Clk,
    input  logic                    rstN,
    input  fwdSrc_t                 wbFwd,
    output logic [NumRegs*XLEN-1:0] regs
);

    logic [XLEN-1:0] regFile [1:NumRegs-1];    // No storage behind r0

    always_ff @(posedge Clk)
    begin
        if (!rstN)
        begin
            for (int i = 1; i < NumRegs; i++)
                regFile[i] <= '0;
        end
        else if (wbFwd.rfEnable && wbFwd.rd != '0)
            regFile[wbFwd.rd] <= wbFwd.value;
    end

    // Flat read bus, slot k holds register k
    assign regs[XLEN-1:0] = '0;

    for (genvar k = 1; k < NumRegs; k++)
    begin : gFlat
        assign regs[k*XLEN +: XLEN] = regFile[k];
    end

    // A WB write shows up in its own slot of the read bus a cycle later
    wbWriteVisible: assert property (
        @(posedge Clk) disable iff (!rstN)
        (wbFwd.rfEnable && wbFwd.rd != '0) |=>
            (regs[$past(wbFwd.rd)*XLEN +: XLEN] == $past(wbFwd.value))
    ) else $error("WB write did not reach its register");

endmodule

//--- controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder import sparcPkg::*;
(
    input  logic [XLEN-1:0]       instr,
    output ctrl_t                 ctrl,
    output logic [REG_ADDR_W-1:0] rd
);

    logic [1:0] op;
    logic [2:0] op2;
    logic [5:0] op3;

    assign op  = instr[31:30];
    assign op2 = instr[24:22];
    assign op3 = instr[24:19];

    assign rd = (op == OP_CALL) ? LINK_REG : instr[29:25];

    always_comb
    begin
        ctrl = '0;    // Everything off means nop

        case (op)
            OP_CALL:
            begin
                ctrl.call     = 1'b1;
                ctrl.rfEnable = 1'b1;   // Writes the return address
            end

            OP_BRANCH:
            begin
                if (op2 == OP2_SETHI)
                begin
                    ctrl.aluOp    = ALU_PASSB;   // imm22 goes through as operand B
                    ctrl.rfEnable = 1'b1;
                end
                else if (instr != '0)
                begin
                    ctrl.branch   = 1'b1;
                    ctrl.annulBit = instr[29];
                end
            end

            OP_ARITH:
            begin
                ctrl.rfEnable = 1'b1;
                if (op3 == OP3_JMPL)
                    ctrl.jmpl = 1'b1;   // Target is rs1 + operand, plain add
                else
                begin
                    ctrl.modifyCc = instr[23];
                    // op3[3:0] picks the operation, bit 24 turns negated logic into shifts
                    case (op3[3:0])
                        4'd0:    ctrl.aluOp = ALU_ADD;
                        4'd8:    ctrl.aluOp = ALU_ADDX;
                        4'd4:    ctrl.aluOp = ALU_SUB;
                        4'd12:   ctrl.aluOp = ALU_SUBX;
                        4'd1:    ctrl.aluOp = ALU_AND;
                        4'd2:    ctrl.aluOp = ALU_OR;
                        4'd3:    ctrl.aluOp = ALU_XOR;
                        4'd5:    ctrl.aluOp = op3[5] ? ALU_SLL : ALU_ANDN;
                        4'd6:    ctrl.aluOp = op3[5] ? ALU_SRL : ALU_ORN;
                        4'd7:    ctrl.aluOp = op3[5] ? ALU_SRA : ALU_XNOR;
                        default: ctrl.aluOp = ALU_ADD;
                    endcase
                end
            end

            OP_MEM:
            begin
                ctrl.memEnable = 1'b1;
                case (op3)
                    OP3_LD, OP3_LDUB, OP3_LDUH, OP3_LDSB, OP3_LDSH:
                    begin
                        ctrl.load     = 1'b1;
                        ctrl.rfEnable = 1'b1;
                        ctrl.signExt  = op3[3];    // Set for ldsb and ldsh
                    end
                    OP3_ST, OP3_STB, OP3_STH:
                        ctrl.store = 1'b1;
                    default:
                        ctrl.memEnable = 1'b0;     // Unsupported access
                endcase

                // Low two op3 bits give the access size for all eight codes
                case (op3[1:0])
                    2'b01:   ctrl.size = SIZE_BYTE;
                    2'b10:   ctrl.size = SIZE_HALF;
                    default: ctrl.size = SIZE_WORD;
                endcase
            end

            default:
                ctrl = '0;
        endcase
    end

endmodule

//--- sparcPkg.sv
package sparcPkg;

    localparam int XLEN           = 32;
    localparam int REG_ADDR_W     = 5;
    localparam int NUM_REGS       = 32;
    localparam int NUM_READ_PORTS = 3;     // rs1, rs2 and store data

    localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd15;   // Return address goes to %o7

    // Major opcodes in instr[31:30]
    localparam logic [1:0] OP_BRANCH = 2'b00;
    localparam logic [1:0] OP_CALL   = 2'b01;
    localparam logic [1:0] OP_ARITH  = 2'b10;
    localparam logic [1:0] OP_MEM    = 2'b11;

    localparam logic [2:0] OP2_SETHI = 3'b100;

    localparam logic [5:0] OP3_JMPL = 6'b111000;
    localparam logic [5:0] OP3_LD   = 6'b000000;
    localparam logic [5:0] OP3_LDUB = 6'b000001;
    localparam logic [5:0] OP3_LDUH = 6'b000010;
    localparam logic [5:0] OP3_LDSB = 6'b001001;
    localparam logic [5:0] OP3_LDSH = 6'b001010;
    localparam logic [5:0] OP3_ST   = 6'b000100;
    localparam logic [5:0] OP3_STB  = 6'b000101;
    localparam logic [5:0] OP3_STH  = 6'b000110;

    // Branch conditions in instr[28:25]
    localparam logic [3:0] COND_BN   = 4'b0000;
    localparam logic [3:0] COND_BE   = 4'b0001;
    localparam logic [3:0] COND_BLE  = 4'b0010;
    localparam logic [3:0] COND_BL   = 4'b0011;
    localparam logic [3:0] COND_BLEU = 4'b0100;
    localparam logic [3:0] COND_BCS  = 4'b0101;
    localparam logic [3:0] COND_BNEG = 4'b0110;
    localparam logic [3:0] COND_BVS  = 4'b0111;
    localparam logic [3:0] COND_BA   = 4'b1000;
    localparam logic [3:0] COND_BNE  = 4'b1001;
    localparam logic [3:0] COND_BG   = 4'b1010;
    localparam logic [3:0] COND_BGE  = 4'b1011;
    localparam logic [3:0] COND_BGU  = 4'b1100;
    localparam logic [3:0] COND_BCC  = 4'b1101;
    localparam logic [3:0] COND_BPOS = 4'b1110;
    localparam logic [3:0] COND_BVC  = 4'b1111;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_ADDX  = 4'd1,
        ALU_SUB   = 4'd2,
        ALU_SUBX  = 4'd3,
        ALU_AND   = 4'd4,
        ALU_OR    = 4'd5,
        ALU_XOR   = 4'd6,
        ALU_XNOR  = 4'd7,
        ALU_ANDN  = 4'd8,
        ALU_ORN   = 4'd9,
        ALU_SLL   = 4'd10,
        ALU_SRL   = 4'd11,
        ALU_SRA   = 4'd12,
        ALU_PASSB = 4'd14
    } aluOp_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } memSize_t;

    typedef struct packed {
        logic     jmpl;
        logic     store;         // 1 = write, 0 = read
        aluOp_t   aluOp;
        logic     signExt;
        logic     load;
        logic     rfEnable;
        memSize_t size;
        logic     modifyCc;
        logic     call;
        logic     memEnable;
        logic     branch;
        logic     annulBit;
    } ctrl_t;

    // Control that travels past ID
    typedef struct packed {
        logic     jmpl;
        logic     store;
        aluOp_t   aluOp;
        logic     signExt;
        logic     load;
        logic     rfEnable;
        memSize_t size;
        logic     modifyCc;
        logic     call;
        logic     memEnable;
    } exCtrl_t;

    typedef struct packed {
        logic                  rfEnable;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
    } fwdSrc_t;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } cc_t;

    typedef struct packed {
        exCtrl_t               ctrl;
        logic [XLEN-1:0]       opA;
        logic [XLEN-1:0]       opB;
        logic [XLEN-1:0]       storeData;
        logic [REG_ADDR_W-1:0] rd;
        logic [21:0]           imm22;
        logic                  isImm;
        logic                  pad;
    } idEx_t;

endpackage
